// ==== verilog/uart_pkg.sv ====
// shared definitions for the UART transmitter and receiver
package uart_pkg;

    // parity bit handling, same for both directions
    typedef enum logic [1:0] {
        PARITY_NONE,    // no parity bit in the frame
        PARITY_ODD,     // ones over data plus parity is odd
        PARITY_EVEN     // ones over data plus parity is even
    } parity_mode_e;

    // one received byte with its status flags
    typedef struct packed {
        logic [7:0] data;       // lsb was first on the line
        logic       parity_err; // parity bit did not match
        logic       frame_err;  // stop bit sampled low
    } rx_result_t;

    // clock cycles per bit, rounded to the nearest whole cycle
    function automatic logic [15:0] baud_div(
        input int clk_freq_hz,
        input int baud_rate
    );
        int cycles;
        cycles = (clk_freq_hz + baud_rate / 2) / baud_rate;
        return 16'(cycles);
    endfunction

endpackage

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
    parameter int                     CLK_FREQ_HZ = 100_000_000,
    parameter int                     BAUD_RATE   = 115_200,
    parameter uart_pkg::parity_mode_e PARITY      = uart_pkg::PARITY_EVEN
) (
    input  logic       CLK_I,
    input  logic       RST_I,
    input  logic [7:0] tx_data,
    input  logic       tx_strobe,
    output logic       tx_busy,
    output logic       txd
);
    import uart_pkg::*;

    localparam logic [15:0] BIT_CYCLES = baud_div(CLK_FREQ_HZ, BAUD_RATE);
    localparam int          FRAME_BITS = (PARITY == PARITY_NONE) ? 10 : 11;
    localparam logic [3:0]  LAST_BIT   = 4'(FRAME_BITS - 1);

    logic        busy;
    logic [10:0] shift_q;       // bit 0 is on the line
    logic [15:0] baud_cnt;
    logic [3:0]  bit_cnt;       // bit of the frame being sent
    logic        par_bit;
    logic [10:0] load_frame;

    // parity over the byte to be loaded
    always_comb begin
        case (PARITY)
            PARITY_ODD:  par_bit = ~(^tx_data);
            PARITY_EVEN: par_bit = ^tx_data;
            default:     par_bit = 1'b1;    // slot holds the stop bit instead
        endcase
    end

    // stop, parity (or stop), data, start
    // without parity the top bit is just idle level
    assign load_frame = {1'b1, par_bit, tx_data, 1'b0};

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            busy     <= 1'b0;
            shift_q  <= '1;     // line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (tx_strobe) begin    // strobes while busy never get here
                busy     <= 1'b1;
                shift_q  <= load_frame;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == BIT_CYCLES - 16'd1) begin
            baud_cnt <= '0;
            shift_q  <= {1'b1, shift_q[10:1]};  // refill with idle level
            if (bit_cnt == LAST_BIT) begin
                busy <= 1'b0;   // end of stop bit
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 16'd1;
        end
    end

    assign tx_busy = busy;
    assign txd     = shift_q[0];

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
    parameter int                     CLK_FREQ_HZ = 100_000_000,
    parameter int                     BAUD_RATE   = 115_200,
    parameter uart_pkg::parity_mode_e PARITY      = uart_pkg::PARITY_EVEN
) (
    input  logic                 CLK_I,
    input  logic                 RST_I,
    input  logic                 rxd,
    output logic                 rx_valid,
    output uart_pkg::rx_result_t rx_result,
    output logic [7:0]           parity_err_cnt
);
    import uart_pkg::*;

    localparam logic [15:0] BIT_CYCLES = baud_div(CLK_FREQ_HZ, BAUD_RATE);
    localparam logic [15:0] MID_CNT    = BIT_CYCLES >> 1;
    localparam logic        ODD_MODE   = (PARITY == PARITY_ODD);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,   // confirm start bit at its middle
        ST_DATA,
        ST_PARITY,
        ST_STOP
    } state_e;

    state_e      state;
    logic        rxd_meta;
    logic        rxd_sync;
    logic [15:0] baud_cnt;      // position inside the current bit
    logic [15:0] baud_next;
    logic        mid_point;
    logic        bit_end;
    logic [2:0]  bit_idx;
    logic [7:0]  shift_data;
    logic        par_acc;       // running xor of the data bits
    logic        parity_bad;

    // two-flop synchroniser, preset high so reset is not seen as a start
    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    assign mid_point = (baud_cnt == MID_CNT);
    assign bit_end   = (baud_cnt == BIT_CYCLES - 16'd1);
    assign baud_next = bit_end ? 16'd0 : baud_cnt + 16'd1;

    // data bits arrive lsb first, shift in from the top
    always_ff @(posedge CLK_I) begin
        if (state == ST_DATA && mid_point) begin
            shift_data <= {rxd_sync, shift_data[7:1]};
        end
    end

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state          <= ST_IDLE;
            baud_cnt       <= '0;
            bit_idx        <= '0;
            par_acc        <= 1'b0;
            parity_bad     <= 1'b0;
            rx_valid       <= 1'b0;
            rx_result      <= '0;
            parity_err_cnt <= '0;
        end else begin
            rx_valid <= 1'b0;   // single-cycle strobe
            case (state)
                ST_IDLE: begin
                    baud_cnt   <= '0;
                    bit_idx    <= '0;
                    par_acc    <= 1'b0;
                    parity_bad <= 1'b0;     // stays clear without parity
                    if (!rxd_sync) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    baud_cnt <= baud_next;
                    if (mid_point && rxd_sync) begin
                        state <= ST_IDLE;   // glitch, line back high
                    end else if (bit_end) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    baud_cnt <= baud_next;
                    if (mid_point) begin
                        par_acc <= par_acc ^ rxd_sync;
                    end
                    if (bit_end) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= (PARITY == PARITY_NONE) ? ST_STOP : ST_PARITY;
                        end
                    end
                end
                ST_PARITY: begin
                    baud_cnt <= baud_next;
                    // par_acc already holds all eight bits here
                    if (mid_point) begin
                        parity_bad <= par_acc ^ rxd_sync ^ ODD_MODE;
                    end
                    if (bit_end) begin
                        state <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    baud_cnt <= baud_next;
                    if (mid_point) begin
                        rx_valid             <= 1'b1;
                        rx_result.data       <= shift_data;
                        rx_result.parity_err <= parity_bad;
                        rx_result.frame_err  <= ~rxd_sync;
                        if (parity_bad && parity_err_cnt != 8'hff) begin
                            parity_err_cnt <= parity_err_cnt + 8'd1;  // saturates
                        end
                        state <= ST_IDLE;   // ready for next start edge
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== verilog/uart_top.sv ====
`timescale 1ns/1ps

module uart_top #(
    parameter int                     CLK_FREQ_HZ = 100_000_000,
    parameter int                     BAUD_RATE   = 115_200,
    parameter uart_pkg::parity_mode_e PARITY      = uart_pkg::PARITY_EVEN
) (
    input  logic                 CLK_I,
    input  logic                 RST_I,
    // transmit side
    input  logic [7:0]           tx_data,
    input  logic                 tx_strobe,
    output logic                 tx_busy,
    output logic                 txd,
    // receive side
    input  logic                 rxd,
    output logic                 rx_valid,
    output uart_pkg::rx_result_t rx_result,
    output logic [7:0]           parity_err_cnt
);

    // the two directions share only clock, reset and line settings
    uart_tx #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD_RATE   (BAUD_RATE),
        .PARITY      (PARITY)
    ) i_uart_tx (
        .CLK_I     (CLK_I),
        .RST_I     (RST_I),
        .tx_data   (tx_data),
        .tx_strobe (tx_strobe),
        .tx_busy   (tx_busy),
        .txd       (txd)
    );

    uart_rx #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD_RATE   (BAUD_RATE),
        .PARITY      (PARITY)
    ) i_uart_rx (
        .CLK_I          (CLK_I),
        .RST_I          (RST_I),
        .rxd            (rxd),      // loopback is closed outside
        .rx_valid       (rx_valid),
        .rx_result      (rx_result),
        .parity_err_cnt (parity_err_cnt)
    );

endmodule

// ==== testbench/uart_checker.sv ====
`timescale 1ns/1ps

module uart_checker #(
    parameter int BUSY_CYCLES = 110    // clock cycles of one transmitted frame
) (
    input  logic                 CLK_I,
    input  logic                 RST_I,
    input  logic                 txd,
    input  logic                 tx_busy,
    input  logic                 rx_valid,
    input  uart_pkg::rx_result_t rx_result,
    input  logic [7:0]           parity_err_cnt,
    input  logic                 idle_watch,    // outputs must sit at reset values
    input  logic                 exp_strobe,
    input  uart_pkg::rx_result_t exp_value,
    output int                   pending,
    output int                   err_cnt
);
    import uart_pkg::*;

    rx_result_t exp_q[$];
    rx_result_t exp_head;
    logic [7:0] cnt_model;  // own copy of the saturating parity error count
    int         busy_run;

    initial begin
        err_cnt = 0;
        pending = 0;
    end

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            err_cnt++;
        end
    endtask

    // values read here are the ones from before this edge
    always @(posedge CLK_I) begin
        if (RST_I) begin
            exp_q.delete();
            cnt_model = 8'd0;
            busy_run  = 0;
            pending   = 0;
        end else begin
            if (idle_watch) begin
                compare_field("txd", 1, txd);
                compare_field("tx_busy", 0, tx_busy);
                compare_field("rx_valid", 0, rx_valid);
                compare_field("rx_result", 0, rx_result);
                compare_field("parity_err_cnt", 0, parity_err_cnt);
            end
            if (rx_valid) begin
                if (exp_q.size() == 0) begin
                    $display("At %0t the receiver reported byte %h although no frame was sent",
                             $time, rx_result.data);
                    err_cnt++;
                end else begin
                    exp_head = exp_q.pop_front();
                    compare_field("rx_result.data", exp_head.data, rx_result.data);
                    compare_field("rx_result.parity_err", exp_head.parity_err,
                                  rx_result.parity_err);
                    compare_field("rx_result.frame_err", exp_head.frame_err,
                                  rx_result.frame_err);
                    if (exp_head.parity_err && cnt_model != 8'hff) begin
                        cnt_model = cnt_model + 8'd1;
                    end
                end
                compare_field("parity_err_cnt", cnt_model, parity_err_cnt);
            end
            // length of each busy period, checked when it ends
            if (tx_busy === 1'b1) begin
                busy_run++;
            end else if (busy_run != 0) begin
                compare_field("tx_busy cycles", BUSY_CYCLES, busy_run);
                busy_run = 0;
            end
            if (exp_strobe) begin
                exp_q.push_back(exp_value);
            end
            pending = exp_q.size();
        end
    end

endmodule

// ==== testbench/tb_uart_top.sv ====
`timescale 1ns/1ps

module tb_uart_top;
    import uart_pkg::*;

    localparam int           CLK_FREQ_HZ = 100_000_000;
    localparam int           BAUD_RATE   = 10_000_000;
    localparam parity_mode_e PARITY      = PARITY_EVEN;
    localparam int           BIT_CYCLES  = CLK_FREQ_HZ / BAUD_RATE;
    localparam int           BUSY_CYCLES = 11 * BIT_CYCLES;    // start, 8 data, parity, stop
    localparam int           WAIT_LIMIT  = 20 * BIT_CYCLES;

    logic       CLK_I;
    logic       RST_I;
    logic [7:0] tx_data;
    logic       tx_strobe;
    logic       tx_busy;
    logic       txd;
    logic       rxd;
    logic       rx_valid;
    rx_result_t rx_result;
    logic [7:0] parity_err_cnt;

    logic       loopback;   // rxd follows txd
    logic       rxd_bang;   // raw line level driven by the testbench
    logic       idle_watch;
    logic       exp_strobe;
    rx_result_t exp_value;
    int         pending;
    int         checker_errs;
    int         timeouts;
    int         other_errs;

    assign rxd = loopback ? txd : rxd_bang;

    always #5 CLK_I = ~CLK_I;

    uart_top #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD_RATE   (BAUD_RATE),
        .PARITY      (PARITY)
    ) i_uart_top (
        .CLK_I          (CLK_I),
        .RST_I          (RST_I),
        .tx_data        (tx_data),
        .tx_strobe      (tx_strobe),
        .tx_busy        (tx_busy),
        .txd            (txd),
        .rxd            (rxd),
        .rx_valid       (rx_valid),
        .rx_result      (rx_result),
        .parity_err_cnt (parity_err_cnt)
    );

    uart_checker #(
        .BUSY_CYCLES (BUSY_CYCLES)
    ) i_uart_checker (
        .CLK_I          (CLK_I),
        .RST_I          (RST_I),
        .txd            (txd),
        .tx_busy        (tx_busy),
        .rx_valid       (rx_valid),
        .rx_result      (rx_result),
        .parity_err_cnt (parity_err_cnt),
        .idle_watch     (idle_watch),
        .exp_strobe     (exp_strobe),
        .exp_value      (exp_value),
        .pending        (pending),
        .err_cnt        (checker_errs)
    );

    // inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge CLK_I);
        #1;
    endtask

    task automatic push_expected(input logic [7:0] data, input logic par_err,
                                 input logic frm_err);
        exp_value  = '{data: data, parity_err: par_err, frame_err: frm_err};
        exp_strobe = 1'b1;
        tick();
        exp_strobe = 1'b0;
    endtask

    task automatic wait_busy_low();
        int n;
        n = 0;
        while (tx_busy && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (tx_busy) begin
            $display("Transmitter stayed busy for %0d cycles at %0t", WAIT_LIMIT, $time);
            timeouts++;
        end
    endtask

    task automatic wait_queue_empty();
        int n;
        n = 0;
        while (pending != 0 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (pending != 0) begin
            $display("Receiver did not deliver %0d expected results by %0t", pending, $time);
            timeouts++;
        end
    endtask

    task automatic strobe_byte(input logic [7:0] data);
        tx_data   = data;
        tx_strobe = 1'b1;
        tick();
        tx_strobe = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] data, input logic twice);
        loopback = 1'b1;
        push_expected(data, 1'b0, 1'b0);
        strobe_byte(data);
        if (twice) begin
            repeat (3 * BIT_CYCLES) tick();
            strobe_byte(~data);     // dropped while the transmitter is busy
        end
        wait_busy_low();
        wait_queue_empty();
    endtask

    task automatic drive_bit(input logic b);
        rxd_bang = b;
        repeat (BIT_CYCLES) tick();
    endtask

    task automatic send_raw_frame(input logic [7:0] data, input logic par,
                                  input logic stop);
        loopback = 1'b0;
        // parity error when data plus parity bit hold an odd count of ones
        push_expected(data, (^data) ^ par, ~stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(par);
        drive_bit(stop);
        rxd_bang = 1'b1;
        wait_queue_empty();
        repeat (2 * BIT_CYCLES) tick();    // lets a low stop bit die out as a false start
    endtask

    task automatic send_glitch();
        loopback = 1'b0;
        rxd_bang = 1'b0;
        repeat (3) tick();
        rxd_bang = 1'b1;
        repeat (2 * BIT_CYCLES) tick();
    endtask

    initial begin
        int         fd;
        int         kind;
        int         n_fields;
        logic [7:0] data_byte;
        logic       par_bit;
        logic       stop_bit;
        string      line;

        CLK_I      = 1'b0;
        RST_I      = 1'b1;
        tx_data    = 8'h00;
        tx_strobe  = 1'b0;
        rxd_bang   = 1'b1;
        loopback   = 1'b0;
        idle_watch = 1'b0;
        exp_strobe = 1'b0;
        exp_value  = '0;
        timeouts   = 0;
        other_errs = 0;
        void'($urandom(32'h3aff_8b58));

        repeat (3) tick();
        RST_I      = 1'b0;
        idle_watch = 1'b1;
        repeat (20) tick();
        idle_watch = 1'b0;

        fd = $fopen("testbench/uart_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n_fields = $sscanf(line, "%h %h %h %h", kind, data_byte, par_bit, stop_bit);
                if (n_fields == 4) begin    // comment and blank lines fall through
                    case (kind)
                        0:       send_byte(data_byte, 1'b0);
                        1:       send_raw_frame(data_byte, par_bit, stop_bit);
                        2:       send_glitch();
                        3:       send_byte(data_byte, 1'b1);
                        default: begin
                            $display("Test data line has unknown kind %0d", kind);
                            other_errs++;
                        end
                    endcase
                    repeat ($urandom_range(20, 0)) tick();
                end
            end
            $fclose(fd);
        end

        repeat (20 * BIT_CYCLES) tick();   // room for any late extra result
        wait_queue_empty();

        $display("checker errors %0d, timeouts %0d, other errors %0d",
                 checker_errs, timeouts, other_errs);
        if (checker_errs == 0 && timeouts == 0 && other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== testbench/uart_testdata.txt ====
// kind data parity stop, all hex
// kind 0 loopback byte, 1 raw frame on rxd, 2 short glitch, 3 second strobe while busy
0 00 0 1
0 ff 0 1
0 55 0 1
0 aa 0 1
0 a5 0 1
0 3c 0 1
1 81 0 1
1 81 1 1
1 7e 1 1
1 01 0 1
1 01 1 1
1 c3 0 0
1 c3 1 0
1 10 1 0
2 00 0 1
0 5a 0 1
2 00 0 1
1 e7 1 1
3 96 0 1
0 0f 0 1
3 f0 0 1
1 ff 0 1
1 ff 1 1
1 00 1 0
0 12 0 1
0 ed 0 1

// ==== flist.f ====
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
testbench/uart_checker.sv
testbench/tb_uart_top.sv
